// ==== gpu_stencil_cache.f ====
common/stencil_pkg.sv
stencil_cache/stencil_addr_decode.sv
stencil_cache/stencil_bank_ram.sv
stencil_cache/stencil_bank.sv
stencil_cache/stencil_read_select.sv
rtl/gpu_stencil_cache.sv
testbench/tb_clock_gen.sv
testbench/tb_gpu_stencil_cache.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_gpu_stencil_cache
FILELIST = gpu_stencil_cache.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/stencil_stim.txt ====
# op addr mask value expected, all hex except op
# op: W write, E write that must raise the error, R read checked, N idle
N 0000 0000 0000 0000
N 0000 0000 0000 0000
W 0100 FFFF 1234 0000
N 0000 0000 0000 0000
R 0100 0000 0000 1234
N 0000 0000 0000 0000
W 0100 00FF AB56 0000
N 0000 0000 0000 0000
W 0100 F000 7000 0000
N 0000 0000 0000 0000
R 0100 0000 0000 7256
W 0101 FFFF 1111 0000
N 0000 0000 0000 0000
W 0140 FFFF 2222 0000
N 0000 0000 0000 0000
W 01C1 FFFF 3333 0000
N 0000 0000 0000 0000
R 0100 0000 0000 7256
R 0101 0000 0000 1111
R 0140 0000 0000 2222
R 01C1 0000 0000 3333
W 0200 FFFF AAAA 0000
E 0202 FFFF BBBB 0000
N 0000 0000 0000 0000
W 0300 FFFF CCCC 0000
W 0301 FFFF DDDD 0000
N 0000 0000 0000 0000
R 0200 0000 0000 AAAA
R 0202 0000 0000 BBBB
R 0300 0000 0000 CCCC
R 0301 0000 0000 DDDD
W 0342 FFFF 5A5A 0000
N 0000 0000 0000 0000
W 0342 0F0F 1234 0000
W 0381 FFFF 9999 0000
N 0000 0000 0000 0000
R 0342 0000 0000 5254
R 0381 0000 0000 9999
N 0000 0000 0000 0000

// ==== testbench/tb_gpu_stencil_cache.sv ====
`timescale 1ns/100ps

module tb_gpu_stencil_cache;
    import stencil_pkg::*;

    localparam string STIM_FILE   = "testbench/stencil_stim.txt";
    localparam int    RAND_WRITES = 16;

    logic                      clk;
    logic                      rst;
    logic                      rd_req   = 1'b0;
    logic [STENCIL_ADDR_W-1:0] rd_addr  = '0;
    logic                      wr_req   = 1'b0;
    logic [STENCIL_ADDR_W-1:0] wr_addr  = '0;
    logic [STENCIL_DATA_W-1:0] wr_mask  = '0;
    logic [STENCIL_DATA_W-1:0] wr_value = '0;
    logic [STENCIL_DATA_W-1:0] rd_value;
    logic                      stencil_error;

    // Stimulus table, one entry per file line
    logic [7:0]                stim_op    [$];
    logic [STENCIL_ADDR_W-1:0] stim_addr  [$];
    logic [STENCIL_DATA_W-1:0] stim_mask  [$];
    logic [STENCIL_DATA_W-1:0] stim_value [$];
    logic [STENCIL_DATA_W-1:0] stim_exp   [$];

    // Reference memory
    logic [STENCIL_DATA_W-1:0] model_mem   [2**STENCIL_ADDR_W];
    logic                      model_valid [2**STENCIL_ADDR_W];

    logic                      pending_rd = 1'b0;
    logic [STENCIL_ADDR_W-1:0] pending_addr;
    logic [STENCIL_DATA_W-1:0] pending_exp;

    int value_errs  = 0;
    int flag_errs   = 0;
    int other_errs  = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;

    tb_clock_gen
    #(
         .PERIOD        (10)
        ,.RESET_CYCLES  (5)
    )
    u_clock_gen
    (
         .clk_o  (clk)
        ,.rst_o  (rst)
    );

    gpu_stencil_cache uut
    (
         .clk_i               (clk)
        ,.rst_i               (rst)
        ,.stencil_rd_req_i    (rd_req)
        ,.stencil_rd_addr_i   (rd_addr)
        ,.stencil_wr_req_i    (wr_req)
        ,.stencil_wr_addr_i   (wr_addr)
        ,.stencil_wr_mask_i   (wr_mask)
        ,.stencil_wr_value_i  (wr_value)
        ,.stencil_rd_value_o  (rd_value)
        ,.stencil_error_o     (stencil_error)
    );

    // ------------------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------------------

    task automatic load_stimulus();
        int                  fd;
        int                  n;
        string               line;
        logic [7:0]          op;
        logic [15:0]         a;
        logic [15:0]         m;
        logic [15:0]         v;
        logic [15:0]         e;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Could not open stimulus file %s", STIM_FILE);
            other_errs++;
            return;
        end
        while ($fgets(line, fd) > 0)
        begin
            // Skip the column description
            if (line.len() > 0 && line.getc(0) != 8'h23)
            begin
                n = $sscanf(line, "%c %h %h %h %h", op, a, m, v, e);
                if (n == 5)
                begin
                    stim_op.push_back(op);
                    stim_addr.push_back(a[STENCIL_ADDR_W-1:0]);
                    stim_mask.push_back(m);
                    stim_value.push_back(v);
                    stim_exp.push_back(e);
                end
            end
        end
        $fclose(fd);
        if (stim_op.size() == 0)
        begin
            $display("Stimulus file holds no usable lines");
            other_errs++;
        end
    endtask

    // New word is the value under the mask, the old word elsewhere
    task automatic model_write(input logic [STENCIL_ADDR_W-1:0] addr,
                               input logic [STENCIL_DATA_W-1:0] mask,
                               input logic [STENCIL_DATA_W-1:0] value);
        if (mask == '1)
        begin
            model_mem[addr]   = value;
            model_valid[addr] = 1'b1;
        end
        else if (model_valid[addr])
            model_mem[addr] = (value & mask) | (model_mem[addr] & ~mask);
    endtask

    task automatic check_read();
        if (pending_rd)
        begin
            assert (rd_value === pending_exp)
            else
            begin
                $display("CHECK FAILED at %0t: stencil_rd_value_o (addr %h) is %h, expected %h",
                         $time, pending_addr, rd_value, pending_exp);
                value_errs++;
            end
            pending_rd = 1'b0;
        end
    endtask

    // One cycle: check the previous read, drive this op, check the error flag
    task automatic step(input logic [7:0]                op,
                        input logic [STENCIL_ADDR_W-1:0] addr,
                        input logic [STENCIL_DATA_W-1:0] mask,
                        input logic [STENCIL_DATA_W-1:0] value,
                        input logic [STENCIL_DATA_W-1:0] exp_value,
                        input logic                      use_exp);
        logic exp_error;
        @(negedge clk);
        check_read();
        rd_req    = 1'b0;
        wr_req    = 1'b0;
        exp_error = (op == "E");
        case (op)
            "W", "E":
            begin
                wr_req   = 1'b1;
                wr_addr  = addr;
                wr_mask  = mask;
                wr_value = value;
            end
            "R":
            begin
                rd_req  = 1'b1;
                rd_addr = addr;
            end
            default: ;
        endcase
        #2;
        assert (stencil_error === exp_error)
        else
        begin
            $display("CHECK FAILED at %0t: stencil_error_o is %b, expected %b",
                     $time, stencil_error, exp_error);
            flag_errs++;
        end
        if (op == "W" || op == "E")
            model_write(addr, mask, value);
        // Never-written words are not checked
        if (op == "R" && model_valid[addr])
        begin
            if (use_exp)
            begin
                assert (model_mem[addr] == exp_value)
                else
                begin
                    $display("Stimulus line expects %h at address %h, the model holds %h",
                             exp_value, addr, model_mem[addr]);
                    other_errs++;
                end
            end
            pending_rd   = 1'b1;
            pending_addr = addr;
            pending_exp  = model_mem[addr];
        end
    endtask

    // Writes kept apart by idle cycles, then read back
    task automatic random_phase();
        logic [STENCIL_ADDR_W-1:0] addrs [RAND_WRITES];
        logic [31:0]               rnd;
        logic [STENCIL_DATA_W-1:0] mask;
        for (int i = 0; i < RAND_WRITES; i++)
        begin
            rnd      = $urandom;
            addrs[i] = rnd[STENCIL_ADDR_W-1:0];
            // About half the writes revisit the previous word to exercise merges
            if (i > 0 && rnd[31])
                addrs[i] = addrs[i-1];
            rnd      = $urandom;
            mask     = rnd[15:0];
            if (rnd[17:16] == 2'b00 || !model_valid[addrs[i]])
                mask = '1;
            rnd = $urandom;
            step("W", addrs[i], mask, rnd[15:0], '0, 1'b0);
            step("N", '0, '0, '0, '0, 1'b0);
        end
        for (int i = 0; i < RAND_WRITES; i++)
            step("R", addrs[i], '0, '0, '0, 1'b0);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence and timeout
    // ------------------------------------------------------------------------

    initial
    begin
        void'($urandom(32'hac2a));
        for (int i = 0; i < 2**STENCIL_ADDR_W; i++)
            model_valid[i] = 1'b0;
        load_stimulus();
        cycle_limit = 4 * stim_op.size() + 200;
        @(posedge clk);
        wait (rst === 1'b0);
        for (int i = 0; i < stim_op.size(); i++)
            step(stim_op[i], stim_addr[i], stim_mask[i], stim_value[i], stim_exp[i], 1'b1);
        random_phase();
        step("N", '0, '0, '0, '0, 1'b0);
        $display("Error counts: read value %0d, error flag %0d, other %0d",
                 value_errs, flag_errs, other_errs);
        if (value_errs + flag_errs + other_errs == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen
#(
     parameter int PERIOD       = 10
    ,parameter int RESET_CYCLES = 5
)
(
     output logic clk_o
    ,output logic rst_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset held over the first edges, released on a falling edge
    initial
    begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// ==== rtl/gpu_stencil_cache.sv ====
`timescale 1ns/100ps

module gpu_stencil_cache
(
     input  logic                               clk_i
    ,input  logic                               rst_i

    // Read request
    ,input  logic                               stencil_rd_req_i
    ,input  logic [stencil_pkg::STENCIL_ADDR_W-1:0] stencil_rd_addr_i

    // Write request
    ,input  logic                               stencil_wr_req_i
    ,input  logic [stencil_pkg::STENCIL_ADDR_W-1:0] stencil_wr_addr_i
    ,input  logic [stencil_pkg::STENCIL_DATA_W-1:0] stencil_wr_mask_i
    ,input  logic [stencil_pkg::STENCIL_DATA_W-1:0] stencil_wr_value_i

    // Result
    ,output logic [stencil_pkg::STENCIL_DATA_W-1:0] stencil_rd_value_o
    ,output logic                               stencil_error_o
);
    import stencil_pkg::*;

    logic [BANK_ROW_W-1:0]                     rd_row;
    logic [BANK_ROW_W-1:0]                     wr_row;
    logic [BANK_ID_W-1:0]                      rd_bank_id;
    logic [NUM_BANKS-1:0]                      rd_bank_en;
    logic [NUM_BANKS-1:0]                      wr_bank_en;
    logic [NUM_BANKS-1:0][STENCIL_DATA_W-1:0]  bank_rd_data;
    logic [NUM_BANKS-1:0]                      bank_error;

    stencil_addr_decode u_decode
    (
         .rd_req_i      (stencil_rd_req_i)
        ,.rd_addr_i     (stencil_rd_addr_i)
        ,.wr_req_i      (stencil_wr_req_i)
        ,.wr_addr_i     (stencil_wr_addr_i)
        ,.rd_row_o      (rd_row)
        ,.wr_row_o      (wr_row)
        ,.rd_bank_id_o  (rd_bank_id)
        ,.rd_bank_en_o  (rd_bank_en)
        ,.wr_bank_en_o  (wr_bank_en)
    );

    // All banks see the same rows and write data, only the enables differ
    for (genvar g = 0; g < NUM_BANKS; g++)
    begin : g_bank
        stencil_bank
        #(
             .ROW_W   (BANK_ROW_W)
            ,.DATA_W  (STENCIL_DATA_W)
        )
        u_bank
        (
             .clk_i       (clk_i)
            ,.rst_i       (rst_i)
            ,.wr_en_i     (wr_bank_en[g])
            ,.wr_row_i    (wr_row)
            ,.wr_mask_i   (stencil_wr_mask_i)
            ,.wr_value_i  (stencil_wr_value_i)
            ,.rd_en_i     (rd_bank_en[g])
            ,.rd_row_i    (rd_row)
            ,.rd_data_o   (bank_rd_data[g])
            ,.error_o     (bank_error[g])
        );
    end

    stencil_read_select u_read_select
    (
         .clk_i         (clk_i)
        ,.rst_i         (rst_i)
        ,.rd_req_i      (stencil_rd_req_i)
        ,.rd_bank_id_i  (rd_bank_id)
        ,.bank_data_i   (bank_rd_data)
        ,.rd_value_o    (stencil_rd_value_o)
    );

    // Any bank written twice in a row
    assign stencil_error_o = |bank_error;

endmodule

// ==== stencil_cache/stencil_read_select.sv ====
`timescale 1ns/100ps

module stencil_read_select
(
     input  logic                                   clk_i
    ,input  logic                                   rst_i
    ,input  logic                                   rd_req_i
    ,input  logic [stencil_pkg::BANK_ID_W-1:0]      rd_bank_id_i
    ,input  logic [stencil_pkg::NUM_BANKS-1:0][stencil_pkg::STENCIL_DATA_W-1:0] bank_data_i
    ,output logic [stencil_pkg::STENCIL_DATA_W-1:0] rd_value_o
);
    import stencil_pkg::*;

    logic [BANK_ID_W-1:0] rd_bank_id_q;

    // Bank of the last read, held until the next request
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            rd_bank_id_q <= '0;
        else if (rd_req_i)
            rd_bank_id_q <= rd_bank_id_i;
    end

    // Bank words are valid one cycle after the request
    assign rd_value_o = bank_data_i[rd_bank_id_q];

    // An unknown id would make the output mux pick garbage
    assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(rd_bank_id_q))
    else $error("stencil read select: bank id unknown");

endmodule

// ==== stencil_cache/stencil_bank.sv ====
`timescale 1ns/100ps

module stencil_bank
#(
     parameter int ROW_W  = 12
    ,parameter int DATA_W = 16
)
(
     input  logic              clk_i
    ,input  logic              rst_i

    // Write port
    ,input  logic              wr_en_i
    ,input  logic [ROW_W-1:0]  wr_row_i
    ,input  logic [DATA_W-1:0] wr_mask_i
    ,input  logic [DATA_W-1:0] wr_value_i

    // Read port
    ,input  logic              rd_en_i
    ,input  logic [ROW_W-1:0]  rd_row_i
    ,output logic [DATA_W-1:0] rd_data_o

    ,output logic              error_o
);
    import stencil_pkg::*;

    wr_state_e         state_q;
    logic              wr_en_q;
    logic              full_mask;
    logic              accept;
    logic [ROW_W-1:0]  merge_row_q;
    logic [DATA_W-1:0] merge_mask_q;
    logic [DATA_W-1:0] merge_value_q;
    logic [ROW_W-1:0]  rd_row_q;
    logic [ROW_W-1:0]  ram_rd_row;
    logic              ram_wr;
    logic [ROW_W-1:0]  ram_wr_row;
    logic [DATA_W-1:0] ram_wr_data;
    logic [DATA_W-1:0] old_word;

    assign full_mask = (wr_mask_i == {DATA_W{1'b1}});

    // A write landing on a pending merge is dropped and flagged as error
    assign accept = wr_en_i && (state_q == WR_IDLE);

    // ------------------------------------------------------------------------
    // Write path FSM
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= WR_IDLE;
            wr_en_q <= 1'b0;
        end
        else
        begin
            state_q <= (accept && !full_mask) ? WR_MERGE : WR_IDLE;
            wr_en_q <= wr_en_i;
        end
    end

    // Masked write waits here for the old word
    always_ff @(posedge clk_i)
    begin
        if (accept && !full_mask)
        begin
            merge_row_q   <= wr_row_i;
            merge_mask_q  <= wr_mask_i;
            merge_value_q <= wr_value_i;
        end
    end

    always_comb
    begin
        if (state_q == WR_MERGE)
        begin
            ram_wr      = 1'b1;
            ram_wr_row  = merge_row_q;
            ram_wr_data = (merge_value_q & merge_mask_q) | (old_word & ~merge_mask_q);
        end
        else
        begin
            ram_wr      = accept && full_mask;
            ram_wr_row  = wr_row_i;
            ram_wr_data = wr_value_i;
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------

    // Keep re-reading the last row so the word holds until the next request
    always_ff @(posedge clk_i)
    begin
        if (rd_en_i)
            rd_row_q <= rd_row_i;
    end

    assign ram_rd_row = rd_en_i ? rd_row_i : rd_row_q;

    stencil_bank_ram
    #(
         .ROW_W   (ROW_W)
        ,.DATA_W  (DATA_W)
    )
    u_ram
    (
         .clk_i           (clk_i)
        ,.rst_i           (rst_i)
        ,.wr_i            (ram_wr)
        ,.wr_row_i        (ram_wr_row)
        ,.wr_data_i       (ram_wr_data)
        ,.rd_row_i        (ram_rd_row)
        ,.wr_port_data_o  (old_word)
        ,.rd_data_o       (rd_data_o)
    );

    // Back-to-back writes to this bank
    assign error_o = wr_en_q && wr_en_i;

    // A merge always finishes in one cycle and never chains
    assert property (@(posedge clk_i) disable iff (rst_i)
        (state_q == WR_MERGE) |=> (state_q == WR_IDLE))
    else $error("stencil bank: WR_MERGE held for two cycles");

endmodule

// ==== stencil_cache/stencil_bank_ram.sv ====
`timescale 1ns/100ps

module stencil_bank_ram
#(
     parameter int ROW_W  = 12
    ,parameter int DATA_W = 16
)
(
     input  logic              clk_i
    ,input  logic              rst_i

    // Write port, with readback of the addressed row
    ,input  logic              wr_i
    ,input  logic [ROW_W-1:0]  wr_row_i
    ,input  logic [DATA_W-1:0] wr_data_i
    ,output logic [DATA_W-1:0] wr_port_data_o

    // Read port
    ,input  logic [ROW_W-1:0]  rd_row_i
    ,output logic [DATA_W-1:0] rd_data_o
);

    logic [DATA_W-1:0] mem [2**ROW_W];

    logic [DATA_W-1:0] wr_port_q;
    logic [DATA_W-1:0] rd_port_q;
    logic [DATA_W-1:0] bypass_data_q;
    logic              wr_bypass_q;
    logic              rd_bypass_q;

    // ------------------------------------------------------------------------
    // Storage and registered reads
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i)
    begin
        if (wr_i)
            mem[wr_row_i] <= wr_data_i;
        wr_port_q <= mem[wr_row_i];
        rd_port_q <= mem[rd_row_i];
    end

    // ------------------------------------------------------------------------
    // Write-to-read bypass
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            wr_bypass_q <= 1'b0;
            rd_bypass_q <= 1'b0;
        end
        else
        begin
            wr_bypass_q <= wr_i;
            rd_bypass_q <= wr_i && (wr_row_i == rd_row_i);
        end
    end

    always_ff @(posedge clk_i)
    begin
        bypass_data_q <= wr_data_i;
    end

    // Registered read sampled the row before the write landed
    assign wr_port_data_o = wr_bypass_q ? bypass_data_q : wr_port_q;
    assign rd_data_o      = rd_bypass_q ? bypass_data_q : rd_port_q;

endmodule

// ==== stencil_cache/stencil_addr_decode.sv ====
`timescale 1ns/100ps

module stencil_addr_decode
(
     input  logic                                   rd_req_i
    ,input  logic [stencil_pkg::STENCIL_ADDR_W-1:0] rd_addr_i
    ,input  logic                                   wr_req_i
    ,input  logic [stencil_pkg::STENCIL_ADDR_W-1:0] wr_addr_i

    ,output logic [stencil_pkg::BANK_ROW_W-1:0]     rd_row_o
    ,output logic [stencil_pkg::BANK_ROW_W-1:0]     wr_row_o
    ,output logic [stencil_pkg::BANK_ID_W-1:0]      rd_bank_id_o
    ,output logic [stencil_pkg::NUM_BANKS-1:0]      rd_bank_en_o
    ,output logic [stencil_pkg::NUM_BANKS-1:0]      wr_bank_en_o
);
    import stencil_pkg::*;

    logic [BANK_ID_W-1:0] wr_bank_id;

    // ------------------------------------------------------------------------
    // Address split
    // ------------------------------------------------------------------------

    // Neighbouring pixels land in different banks
    assign rd_bank_id_o = {rd_addr_i[7:6], rd_addr_i[0]};
    assign wr_bank_id   = {wr_addr_i[7:6], wr_addr_i[0]};

    assign rd_row_o = {rd_addr_i[14:8], rd_addr_i[5:1]};
    assign wr_row_o = {wr_addr_i[14:8], wr_addr_i[5:1]};

    // ------------------------------------------------------------------------
    // Per-bank enables
    // ------------------------------------------------------------------------

    always_comb
    begin
        for (int i = 0; i < NUM_BANKS; i++)
        begin
            rd_bank_en_o[i] = rd_req_i && (rd_bank_id_o == BANK_ID_W'(i));
            wr_bank_en_o[i] = wr_req_i && (wr_bank_id == BANK_ID_W'(i));
        end
    end

    // At most one bank addressed per port
    always_comb
    begin
        assert ($onehot0(rd_bank_en_o) && $onehot0(wr_bank_en_o))
        else $error("stencil decode: more than one bank enabled");
    end

endmodule

// ==== common/stencil_pkg.sv ====
package stencil_pkg;

    // ------------------------------------------------------------------------
    // Address and data geometry
    // ------------------------------------------------------------------------

    // Full stencil address, covering 32K words
    localparam int STENCIL_ADDR_W = 15;

    // Stencil word and write mask
    localparam int STENCIL_DATA_W = 16;

    // Bank id is built from address bits 7:6 and bit 0
    localparam int BANK_ID_W = 3;
    localparam int NUM_BANKS = 8;

    // Row inside a bank, from address bits 14:8 and 5:1
    localparam int BANK_ROW_W = 12;

    // ------------------------------------------------------------------------
    // Bank write path
    // ------------------------------------------------------------------------

    // WR_MERGE holds a masked write for one cycle
    // while the old word comes back from the RAM
    typedef enum logic [0:0]
    {
        WR_IDLE  = 1'b0,
        WR_MERGE = 1'b1
    } wr_state_e;

endpackage
